// ==== verilog.f ====
+incdir+include
logic/csr_pkg.sv
logic/csr_event_counters.sv
logic/fcsr_file.sv
logic/csr_read_mux.sv
logic/csr_access_ctrl.sv
logic/csr_unit.sv
sim/tb_clock_gen.sv
sim/csr_unit_checker.sv
sim/csr_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the CSR unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module csr_unit_tb -o csr_unit_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/csr_unit_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST OK" sim.log; then
    exit 0
fi
exit 1

// ==== sim/csr_unit_tb.sv ====
// CSR unit testbench
`include "csr_defs.svh"

module csr_unit_tb import csr_pkg::*; ();

    localparam int dut_core_id = 5;
    // About 180 accesses of four cycles plus the update phases, with a wide margin
    localparam int timeout_cycles = 4000;
    localparam logic [11:0] id_addrs [11] = '{
        `CSR_MVENDORID, `CSR_MARCHID, `CSR_MIMPID, `CSR_MISA, `CSR_CORE_ID, `CSR_WARP_MASK,
        `CSR_NUM_THREADS, `CSR_NUM_WARPS, `CSR_NUM_CORES, `CSR_WARP_ID, `CSR_THREAD_MASK
    };

    logic clk;
    logic reset;
    logic req;
    logic ack;
    logic acc_write_en;
    csr_req_t req_data;
    csr_rsp_t rsp;
    fpu_flag_upd_t [`NUM_FPU_BLOCKS-1:0] fpu_upd;
    logic [`NUM_FPU_BLOCKS-1:0][`WID_BITS-1:0] frm_wid;
    logic [`NUM_FPU_BLOCKS-1:0][`FRM_BITS-1:0] frm;
    logic [`NUM_WARPS-1:0] active_warps;
    logic [`NUM_WARPS-1:0][`NUM_THREADS-1:0] thread_masks;
    logic [2:0] commit_count;
    logic [31:0] acc_read_data;
    logic [31:0] acc_write_data;

    // Reference model state
    logic [`NUM_WARPS-1:0][`FFLAGS_BITS-1:0] m_flags;
    logic [`NUM_WARPS-1:0][`FRM_BITS-1:0] m_frm;
    logic [`CTR_BITS-1:0] m_instret;

    csr_rsp_t exp_rsp;
    csr_rsp_t got_rsp;
    string test_name;
    logic check_en = 1'b0;
    logic ack_prev = 1'b0;
    logic [31:0] last_acc_data;
    logic [31:0] rnd;
    logic [31:0] first_cycle;
    int seed = 4627;
    int cmp_errors = 0;
    int other_errors = 0;
    int cycles = 0;
    int pulses = 0;
    int pulses_before;

    tb_clock_gen clock_gen (.clk(clk), .reset(reset));

    csr_unit #(.core_id(dut_core_id)) uut (.*);

    function automatic csr_rsp_t expected_rsp(csr_req_t r);
        csr_rsp_t e;
        logic wr_ok;
        wr_ok = r.addr inside {`CSR_FFLAGS, `CSR_FRM, `CSR_FCSR, `CSR_SATP, `CSR_MSTATUS,
            `CSR_MEDELEG, `CSR_MIDELEG, `CSR_MIE, `CSR_MTVEC, `CSR_MEPC, `CSR_PMPCFG0,
            `CSR_PMPADDR0, `CSR_ACCEL};
        e.data = '0;
        e.err  = !wr_ok;
        if (r.op == CSR_READ) begin
            e.err = 1'b0;
            case (r.addr)
                `CSR_MVENDORID:   e.data = `VENDOR_ID;
                `CSR_MARCHID:     e.data = `ARCH_ID;
                `CSR_MIMPID:      e.data = `IMPL_ID;
                `CSR_MISA:        e.data = `MISA_VALUE;
                `CSR_FFLAGS:      e.data = 32'(m_flags[r.wid]);
                `CSR_FRM:         e.data = 32'(m_frm[r.wid]);
                `CSR_FCSR:        e.data = {24'b0, m_frm[r.wid], m_flags[r.wid]};
                `CSR_WARP_ID:     e.data = 32'(r.wid);
                `CSR_CORE_ID:     e.data = dut_core_id;
                `CSR_THREAD_MASK: e.data = 32'(thread_masks[r.wid]);
                `CSR_WARP_MASK:   e.data = 32'(active_warps);
                `CSR_NUM_THREADS: e.data = `NUM_THREADS;
                `CSR_NUM_WARPS:   e.data = `NUM_WARPS;
                `CSR_NUM_CORES:   e.data = `NUM_CORES;
                `CSR_MINSTRET:    e.data = m_instret[31:0];
                `CSR_MINSTRET_H:  e.data = m_instret[63:32];
                `CSR_ACCEL:       e.data = acc_read_data;
                // Machine stubs read zero, the rest is unmapped
                default:          e.err = !wr_ok;
            endcase
        end
        return e;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
        assert (act == exp) else begin
            other_errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic run_access(input string name, input csr_op_e op, input logic [1:0] wid,
                              input logic [11:0] addr, input logic [31:0] data, input logic check);
        csr_req_t r;
        r.op   = op;
        r.wid  = wid;
        r.addr = addr;
        r.data = data;
        @(negedge clk);
        exp_rsp   = expected_rsp(r);
        test_name = name;
        check_en  = check;
        // Software writes into the floating-point model
        if (op == CSR_WRITE && (addr == `CSR_FFLAGS || addr == `CSR_FCSR))
            m_flags[wid] = data[4:0];
        if (op == CSR_WRITE && addr == `CSR_FRM)
            m_frm[wid] = data[2:0];
        if (op == CSR_WRITE && addr == `CSR_FCSR)
            m_frm[wid] = data[7:5];
        req_data = r;
        req      = 1'b1;
        do @(negedge clk); while (!ack);
        req = 1'b0;
        do @(negedge clk); while (ack);
    endtask

    // Response taken at the first falling edge with ack high
    always @(negedge clk) begin
        if (ack && !ack_prev) begin
            got_rsp = rsp;
            if (check_en) begin
                assert (rsp == exp_rsp) else begin
                    cmp_errors++;
                    $display("CHECK FAILED %s: expected %h, actual %h", test_name, exp_rsp, rsp);
                end
            end
        end
        ack_prev = ack;
    end

    always @(negedge clk) begin
        if (acc_write_en) begin
            pulses++;
            last_acc_data = acc_write_data;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        req          = 1'b0;
        req_data     = '0;
        fpu_upd      = '0;
        frm_wid      = '0;
        commit_count = '0;
        active_warps = 4'b1011;
        rnd          = $random(seed);
        thread_masks = rnd[15:0];
        rnd          = $random(seed);
        acc_read_data = rnd;
        m_flags      = '0;
        m_frm        = '0;
        m_instret    = '0;
        wait (!reset);

        for (int w = 0; w < `NUM_WARPS; w++)
            foreach (id_addrs[i])
                run_access($sformatf("identity %h", id_addrs[i]), CSR_READ, w[1:0],
                           id_addrs[i], '0, 1'b1);

        // Per-warp FCSR writes, each followed by a sweep of all warps
        for (int w = 0; w < `NUM_WARPS; w++) begin
            repeat (3) begin
                rnd = $random(seed);
                run_access("fcsr_write", CSR_WRITE, w[1:0], `CSR_FCSR, rnd, 1'b1);
                run_access("fflags_read", CSR_READ, w[1:0], `CSR_FFLAGS, '0, 1'b1);
                rnd = $random(seed);
                run_access("frm_write", CSR_WRITE, w[1:0], `CSR_FRM, rnd, 1'b1);
                run_access("frm_read", CSR_READ, w[1:0], `CSR_FRM, '0, 1'b1);
                rnd = $random(seed);
                run_access("fflags_write", CSR_WRITE, w[1:0], `CSR_FFLAGS, rnd, 1'b1);
                for (int v = 0; v < `NUM_WARPS; v++)
                    run_access("fcsr_read", CSR_READ, v[1:0], `CSR_FCSR, '0, 1'b1);
            end
        end

        repeat (40) begin
            @(negedge clk);
            for (int i = 0; i < `NUM_FPU_BLOCKS; i++) begin
                compare_value("frm_lookup", 64'(m_frm[frm_wid[i]]), 64'(frm[i]));
                rnd = $random(seed);
                fpu_upd[i].valid = rnd[8];
                fpu_upd[i].wid   = rnd[7:6];
                fpu_upd[i].flags = rnd[4:0];
                frm_wid[i]       = rnd[10:9];
                if (rnd[8])
                    m_flags[rnd[7:6]] = m_flags[rnd[7:6]] | rnd[4:0];
            end
        end
        @(negedge clk);
        fpu_upd = '0;
        for (int w = 0; w < `NUM_WARPS; w++)
            run_access("fflags_accum", CSR_READ, w[1:0], `CSR_FFLAGS, '0, 1'b1);

        pulses_before = pulses;
        rnd = $random(seed);
        run_access("acc_write", CSR_WRITE, 2'd2, `CSR_ACCEL, rnd, 1'b1);
        compare_value("acc_pulses", 64'(pulses_before + 1), 64'(pulses));
        compare_value("acc_write_data", 64'(rnd), 64'(last_acc_data));
        run_access("acc_read", CSR_READ, 2'd2, `CSR_ACCEL, '0, 1'b1);
        run_access("stub_write", CSR_WRITE, 2'd2, `CSR_MSTATUS, rnd, 1'b1);
        run_access("stub_write", CSR_WRITE, 2'd2, `CSR_PMPADDR0, rnd, 1'b1);
        run_access("stub_read", CSR_READ, 2'd2, `CSR_MSTATUS, '0, 1'b1);
        run_access("stub_read", CSR_READ, 2'd2, `CSR_MTVEC, '0, 1'b1);
        compare_value("stub_pulses", 64'(pulses_before + 1), 64'(pulses));

        repeat (30) begin
            @(negedge clk);
            rnd = $random(seed);
            commit_count = rnd[2:0];
            m_instret = m_instret + 64'(rnd[2:0]);
        end
        @(negedge clk);
        commit_count = '0;
        run_access("minstret_lo", CSR_READ, 2'd0, `CSR_MINSTRET, '0, 1'b1);
        run_access("minstret_hi", CSR_READ, 2'd0, `CSR_MINSTRET_H, '0, 1'b1);
        run_access("mcycle", CSR_READ, 2'd0, `CSR_MCYCLE, '0, 1'b0);
        first_cycle = got_rsp.data;
        run_access("mcycle", CSR_READ, 2'd0, `CSR_MCYCLE, '0, 1'b0);
        assert (got_rsp.data > first_cycle) else begin
            other_errors++;
            $display("CHECK FAILED mcycle_increase: expected above %h, actual %h",
                     first_cycle, got_rsp.data);
        end

        run_access("invalid_read", CSR_READ, 2'd3, 12'h7FF, '0, 1'b1);
        run_access("invalid_read", CSR_READ, 2'd3, 12'hCC8, '0, 1'b1);
        rnd = $random(seed);
        run_access("invalid_write", CSR_WRITE, 2'd3, 12'h123, rnd, 1'b1);
        run_access("invalid_write", CSR_WRITE, 2'd3, `CSR_MVENDORID, rnd, 1'b1);
        for (int w = 0; w < `NUM_WARPS; w++)
            run_access("fcsr_after_invalid", CSR_READ, w[1:0], `CSR_FCSR, '0, 1'b1);

        repeat (4) @(negedge clk);
        $display("Errors: %0d response, %0d other", cmp_errors, other_errors);
        if (cmp_errors == 0 && other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== sim/csr_unit_checker.sv ====
// CSR access port assertions
module csr_unit_checker import csr_pkg::*; (
    input logic     clk,
    input logic     reset,
    input logic     req,
    input logic     ack,
    input csr_rsp_t rsp,
    input logic     acc_write_en
);

    // ack only follows a sampled request
    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(ack) |-> $past(req))
        else $error("ack rose without a request");

    ack_holds: assert property (@(posedge clk) disable iff (reset)
        ack && req |=> ack)
        else $error("ack dropped while req was still high");

    rsp_stable: assert property (@(posedge clk) disable iff (reset)
        ack && $past(ack) |-> $stable(rsp))
        else $error("response changed while ack was high");

    acc_single_pulse: assert property (@(posedge clk) disable iff (reset)
        acc_write_en |=> !acc_write_en)
        else $error("acc_write_en stayed high for two cycles");

endmodule

bind csr_unit csr_unit_checker checker_i (.*);

// ==== sim/tb_clock_gen.sv ====
// Testbench clock and reset
module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // Period of 8
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== logic/csr_unit.sv ====
// GPU core CSR unit
`include "csr_defs.svh"

module csr_unit import csr_pkg::*; #(
    parameter int core_id = 0
) (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          req,
    input  csr_req_t                                      req_data,
    output logic                                          ack,
    output csr_rsp_t                                      rsp,
    input  fpu_flag_upd_t [`NUM_FPU_BLOCKS-1:0]           fpu_upd,
    input  logic [`NUM_FPU_BLOCKS-1:0][`WID_BITS-1:0]     frm_wid,
    output logic [`NUM_FPU_BLOCKS-1:0][`FRM_BITS-1:0]     frm,
    input  logic [`NUM_WARPS-1:0]                         active_warps,
    input  logic [`NUM_WARPS-1:0][`NUM_THREADS-1:0]       thread_masks,
    input  logic [2:0]                                    commit_count,
    input  logic [31:0]                                   acc_read_data,
    output logic [31:0]                                   acc_write_data,
    output logic                                          acc_write_en
);

    logic [31:0]               read_data;
    logic                      read_valid;
    logic [`WID_BITS-1:0]      wr_wid;
    logic [`CSR_ADDR_BITS-1:0] wr_addr;
    logic [31:0]               wr_data;
    logic                      wr_en;
    logic [`FFLAGS_BITS-1:0]   rd_fflags;
    logic [`FRM_BITS-1:0]      rd_frm;
    logic [`CTR_BITS-1:0]      mcycle;
    logic [`CTR_BITS-1:0]      minstret;

    csr_access_ctrl access_ctrl (
        .clk            (clk),
        .reset          (reset),
        .req            (req),
        .req_data       (req_data),
        .ack            (ack),
        .rsp            (rsp),
        .read_data      (read_data),
        .read_valid     (read_valid),
        .wr_wid         (wr_wid),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .wr_en          (wr_en),
        .acc_write_data (acc_write_data),
        .acc_write_en   (acc_write_en)
    );

    fcsr_file fcsr (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_wid    (wr_wid),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .fpu_upd   (fpu_upd),
        .frm_wid   (frm_wid),
        .frm       (frm),
        .rd_wid    (req_data.wid),
        .rd_fflags (rd_fflags),
        .rd_frm    (rd_frm)
    );

    csr_event_counters counters (
        .clk          (clk),
        .reset        (reset),
        .commit_count (commit_count),
        .mcycle       (mcycle),
        .minstret     (minstret)
    );

    // Decoder sees the request fields held by the requester
    csr_read_mux #(
        .core_id (core_id)
    ) read_mux (
        .rd_wid        (req_data.wid),
        .rd_addr       (req_data.addr),
        .rd_fflags     (rd_fflags),
        .rd_frm        (rd_frm),
        .mcycle        (mcycle),
        .minstret      (minstret),
        .active_warps  (active_warps),
        .thread_masks  (thread_masks),
        .acc_read_data (acc_read_data),
        .read_data     (read_data),
        .read_valid    (read_valid)
    );

endmodule

// ==== logic/csr_access_ctrl.sv ====
// CSR access port controller
`include "csr_defs.svh"

module csr_access_ctrl import csr_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      req,
    input  csr_req_t                  req_data,
    output logic                      ack,
    output csr_rsp_t                  rsp,
    input  logic [31:0]               read_data,
    input  logic                      read_valid,
    output logic [`WID_BITS-1:0]      wr_wid,
    output logic [`CSR_ADDR_BITS-1:0] wr_addr,
    output logic [31:0]               wr_data,
    output logic                      wr_en,
    output logic [31:0]               acc_write_data,
    output logic                      acc_write_en
);

    access_state_e state;
    logic          access;
    logic          is_write;
    logic          wr_addr_ok;

    // One access per handshake, taken in idle
    assign access   = (state == ST_IDLE) && req;
    assign is_write = (req_data.op == CSR_WRITE);
    assign ack      = (state == ST_ACK);

    always_comb begin
        case (req_data.addr)
            `CSR_FFLAGS,
            `CSR_FRM,
            `CSR_FCSR,
            `CSR_SATP,
            `CSR_MSTATUS,
            `CSR_MEDELEG,
            `CSR_MIDELEG,
            `CSR_MIE,
            `CSR_MTVEC,
            `CSR_MEPC,
            `CSR_PMPCFG0,
            `CSR_PMPADDR0,
            `CSR_ACCEL: wr_addr_ok = 1'b1;
            default:    wr_addr_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= ST_IDLE;
            wr_en        <= 1'b0;
            acc_write_en <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: if (req) state <= ST_ACK;
                ST_ACK:  if (!req) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
            wr_en        <= access && is_write && wr_addr_ok;
            acc_write_en <= access && is_write && (req_data.addr == `CSR_ACCEL);
        end
    end

    // Response and write fields held until the next access
    always_ff @(posedge clk) begin
        if (access) begin
            if (is_write) begin
                rsp.data <= '0;
                rsp.err  <= !wr_addr_ok;
            end else begin
                rsp.data <= read_data;
                rsp.err  <= !read_valid;
            end
            wr_wid  <= req_data.wid;
            wr_addr <= req_data.addr;
            wr_data <= req_data.data;
        end
    end

    assign acc_write_data = wr_data;

endmodule

// ==== logic/csr_read_mux.sv ====
// CSR read decoder
`include "csr_defs.svh"

module csr_read_mux #(
    parameter int core_id = 0
) (
    input  logic [`WID_BITS-1:0]                    rd_wid,
    input  logic [`CSR_ADDR_BITS-1:0]               rd_addr,
    input  logic [`FFLAGS_BITS-1:0]                 rd_fflags,
    input  logic [`FRM_BITS-1:0]                    rd_frm,
    input  logic [`CTR_BITS-1:0]                    mcycle,
    input  logic [`CTR_BITS-1:0]                    minstret,
    input  logic [`NUM_WARPS-1:0]                   active_warps,
    input  logic [`NUM_WARPS-1:0][`NUM_THREADS-1:0] thread_masks,
    input  logic [31:0]                             acc_read_data,
    output logic [31:0]                             read_data,
    output logic                                    read_valid
);

    always_comb begin
        read_data  = '0;
        read_valid = 1'b1;
        case (rd_addr)
            `CSR_MVENDORID:   read_data = `VENDOR_ID;
            `CSR_MARCHID:     read_data = `ARCH_ID;
            `CSR_MIMPID:      read_data = `IMPL_ID;
            `CSR_MISA:        read_data = `MISA_VALUE;

            `CSR_FFLAGS:      read_data = 32'(rd_fflags);
            `CSR_FRM:         read_data = 32'(rd_frm);
            // Rounding mode sits above the flags
            `CSR_FCSR:        read_data = 32'({rd_frm, rd_fflags});

            `CSR_WARP_ID:     read_data = 32'(rd_wid);
            `CSR_CORE_ID:     read_data = 32'(core_id);
            `CSR_THREAD_MASK: read_data = 32'(thread_masks[rd_wid]);
            `CSR_WARP_MASK:   read_data = 32'(active_warps);
            `CSR_NUM_THREADS: read_data = 32'(`NUM_THREADS);
            `CSR_NUM_WARPS:   read_data = 32'(`NUM_WARPS);
            `CSR_NUM_CORES:   read_data = 32'(`NUM_CORES);

            `CSR_MCYCLE:      read_data = mcycle[31:0];
            `CSR_MCYCLE_H:    read_data = mcycle[`CTR_BITS-1:32];
            `CSR_MINSTRET:    read_data = minstret[31:0];
            `CSR_MINSTRET_H:  read_data = minstret[`CTR_BITS-1:32];

            `CSR_SATP,
            `CSR_MSTATUS,
            `CSR_MEDELEG,
            `CSR_MIDELEG,
            `CSR_MIE,
            `CSR_MTVEC,
            `CSR_MEPC,
            `CSR_PMPCFG0,
            `CSR_PMPADDR0:    read_data = '0;

            `CSR_ACCEL:       read_data = acc_read_data;

            default:          read_valid = 1'b0;
        endcase
    end

endmodule

// ==== logic/fcsr_file.sv ====
// Per-warp floating-point CSR file
`include "csr_defs.svh"

module fcsr_file import csr_pkg::*; (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      wr_en,
    input  logic [`WID_BITS-1:0]                      wr_wid,
    input  logic [`CSR_ADDR_BITS-1:0]                 wr_addr,
    input  logic [31:0]                               wr_data,
    input  fpu_flag_upd_t [`NUM_FPU_BLOCKS-1:0]       fpu_upd,
    input  logic [`NUM_FPU_BLOCKS-1:0][`WID_BITS-1:0] frm_wid,
    output logic [`NUM_FPU_BLOCKS-1:0][`FRM_BITS-1:0] frm,
    input  logic [`WID_BITS-1:0]                      rd_wid,
    output logic [`FFLAGS_BITS-1:0]                   rd_fflags,
    output logic [`FRM_BITS-1:0]                      rd_frm
);

    logic [`NUM_WARPS-1:0][`FFLAGS_BITS-1:0] fflags_q;
    logic [`NUM_WARPS-1:0][`FFLAGS_BITS-1:0] fflags_n;
    logic [`NUM_WARPS-1:0][`FRM_BITS-1:0]    frm_q;
    logic [`NUM_WARPS-1:0][`FRM_BITS-1:0]    frm_n;

    always_comb begin
        fflags_n = fflags_q;
        frm_n    = frm_q;
        // Accrued flags from the FPU blocks
        for (int i = 0; i < `NUM_FPU_BLOCKS; i++) begin
            if (fpu_upd[i].valid) begin
                fflags_n[fpu_upd[i].wid] = fflags_n[fpu_upd[i].wid] | fpu_upd[i].flags;
            end
        end
        // Software write overrides the same field
        if (wr_en) begin
            case (wr_addr)
                `CSR_FFLAGS: fflags_n[wr_wid] = wr_data[`FFLAGS_BITS-1:0];
                `CSR_FRM:    frm_n[wr_wid] = wr_data[`FRM_BITS-1:0];
                `CSR_FCSR: begin
                    fflags_n[wr_wid] = wr_data[`FFLAGS_BITS-1:0];
                    frm_n[wr_wid]    = wr_data[`FFLAGS_BITS+`FRM_BITS-1:`FFLAGS_BITS];
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fflags_q <= '0;
            frm_q    <= '0;
        end else begin
            fflags_q <= fflags_n;
            frm_q    <= frm_n;
        end
    end

    // Rounding mode lookup per FPU block
    always_comb begin
        for (int i = 0; i < `NUM_FPU_BLOCKS; i++) begin
            frm[i] = frm_q[frm_wid[i]];
        end
    end

    assign rd_fflags = fflags_q[rd_wid];
    assign rd_frm    = frm_q[rd_wid];

endmodule

// ==== logic/csr_event_counters.sv ====
// Cycle and retired-instruction counters
`include "csr_defs.svh"

module csr_event_counters (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [2:0]           commit_count,
    output logic [`CTR_BITS-1:0] mcycle,
    output logic [`CTR_BITS-1:0] minstret
);

    always_ff @(posedge clk) begin
        if (reset) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            mcycle   <= mcycle + 1'b1;
            // Several instructions may retire per cycle
            minstret <= minstret + {{(`CTR_BITS-3){1'b0}}, commit_count};
        end
    end

endmodule

// ==== logic/csr_pkg.sv ====
// CSR unit types
`include "csr_defs.svh"

package csr_pkg;

    typedef enum logic {
        CSR_READ  = 1'b0,
        CSR_WRITE = 1'b1
    } csr_op_e;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_ACK  = 1'b1
    } access_state_e;

    // Access port request, 47 bits
    typedef struct packed {
        csr_op_e                   op;
        logic [`WID_BITS-1:0]      wid;
        logic [`CSR_ADDR_BITS-1:0] addr;
        logic [31:0]               data;
    } csr_req_t;

    // Access port response, 33 bits
    typedef struct packed {
        logic [31:0] data;
        logic        err;
    } csr_rsp_t;

    // Exception flags from one FPU block
    typedef struct packed {
        logic                    valid;
        logic [`WID_BITS-1:0]    wid;
        logic [`FFLAGS_BITS-1:0] flags;
    } fpu_flag_upd_t;

endpackage

// ==== include/csr_defs.svh ====
// CSR unit sizes and addresses
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// Core geometry
`define NUM_WARPS       4
`define NUM_THREADS     4
`define NUM_CORES       8
`define NUM_FPU_BLOCKS  2
`define WID_BITS        2

`define CSR_ADDR_BITS   12
`define FFLAGS_BITS     5
`define FRM_BITS        3
`define CTR_BITS        64

// Floating-point CSRs
`define CSR_FFLAGS      12'h001
`define CSR_FRM         12'h002
`define CSR_FCSR        12'h003

// Machine CSRs, stubs except MISA
`define CSR_SATP        12'h180
`define CSR_MSTATUS     12'h300
`define CSR_MISA        12'h301
`define CSR_MEDELEG     12'h302
`define CSR_MIDELEG     12'h303
`define CSR_MIE         12'h304
`define CSR_MTVEC       12'h305
`define CSR_MEPC        12'h341
`define CSR_PMPCFG0     12'h3A0
`define CSR_PMPADDR0    12'h3B0

// Counters
`define CSR_MCYCLE      12'hB00
`define CSR_MINSTRET    12'hB02
`define CSR_MCYCLE_H    12'hB80
`define CSR_MINSTRET_H  12'hB82

// Machine identity
`define CSR_MVENDORID   12'hF11
`define CSR_MARCHID     12'hF12
`define CSR_MIMPID      12'hF13

// Custom GPU block
`define CSR_WARP_ID     12'hCC0
`define CSR_CORE_ID     12'hCC1
`define CSR_THREAD_MASK 12'hCC2
`define CSR_WARP_MASK   12'hCC3
`define CSR_NUM_THREADS 12'hCC4
`define CSR_NUM_WARPS   12'hCC5
`define CSR_NUM_CORES   12'hCC6

`define CSR_ACCEL       12'h7C0

`define VENDOR_ID       32'h0000_0001
`define ARCH_ID         32'h0000_0002
`define IMPL_ID         32'h0000_0003
// RV32 with I, M and F
`define MISA_VALUE      32'h4000_1120

`endif
